//--- bench/stream_patterns.txt
// one 64-bit fetch word per line in hex, written in this order
// lane 0 is the low 16 bits and leaves the unpacker first
0003000200010000
0007000600050004
deadbeefcafef00d
123456789abcdef0
fedcba9876543210
00ff00ff00ff00ff
ff00ff00ff00ff00
8000400020001000
0001000200040008
a5a55a5a3c3cc3c3
7fff8000ffff0000
1357246813572468
0badf00d0bad1dea
5555aaaa33339999
c001d00dbeef0042
ffffffffffffffff

//--- compile.f
+incdir+verilog
verilog/deagg_pkg.sv
verilog/lane_fifo.sv
verilog/fetch_buffer.sv
verilog/deaggregator.sv
verilog/stream_unpacker.sv
bench/tb_clock.sv
bench/stream_unpacker_sva.sv
bench/stream_unpacker_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module stream_unpacker_tb -f compile.f -o sim_stream_unpacker
./obj_dir/sim_stream_unpacker > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

//--- bench/stream_unpacker_tb.sv
`include "deagg_config.svh"

module stream_unpacker_tb import deagg_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_WORDS = 16;
  localparam int LANES = `DEAGG_FETCH_WIDTH;
  localparam int LW = `DEAGG_DATA_WIDTH;
  // eight cycles per lane plus slack for reset and the stall
  localparam int WATCHDOG_CYCLES = NUM_WORDS * LANES * 8 + 200;
  // stimulus modes of one cycle
  localparam int CLEAR = 0;
  localparam int RANDOM = 1;
  localparam int STALL = 2;

  logic        clk;
  logic        rst_n;
  fetch_word_u in_data;
  logic        in_enq;
  logic        in_full_n;
  lane_t       out_data;
  logic        out_enq;
  logic        out_full_n;

  logic [LANES*LW-1:0] words [NUM_WORDS];
  lane_t       expected [$];
  logic [31:0] rng;
  int          wr_idx;
  int          out_count;
  int          check_count;
  int          error_count;
  int          stall_cycles;
  string       test_name;

  tb_clock u_clock (
    .clk (clk)
  );

  stream_unpacker uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_data    (in_data),
    .in_enq     (in_enq),
    .in_full_n  (in_full_n),
    .out_data   (out_data),
    .out_enq    (out_enq),
    .out_full_n (out_full_n)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    error_count++;
    $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
  endtask

  // drives one cycle of stimulus on the falling edge
  // a write is attempted only while the buffer reports space
  task automatic drive_cycle(input int mode);
    bit attempt;
    @(negedge clk);
    rng = xorshift32(rng);
    attempt = (mode == RANDOM) ? rng[20] : 1'b1;
    if (mode == STALL) begin
      out_full_n = 1'b0;
    end else begin
      // about one cycle in three is back-pressured in random mode
      out_full_n = (mode == RANDOM) ? (rng % 32'd3 != 32'd0) : 1'b1;
    end
    if (attempt && in_full_n && wr_idx < NUM_WORDS) begin
      in_enq = 1'b1;
      in_data.flat = words[wr_idx];
      wr_idx++;
    end else begin
      in_enq = 1'b0;
    end
  endtask

  // every transfer must match the next lane of the written stream
  always @(posedge clk) begin
    if (rst_n) begin
      if (out_enq) begin
        error_count++;
        $display("out_enq pulsed while reset was held");
      end
    end else if (out_enq) begin
      out_count++;
      if (!out_full_n) begin
        error_count++;
        $display("out_enq pulsed while out_full_n was low");
      end
      if (expected.size() == 0) begin
        error_count++;
        $display("out_enq pulsed with no lane left to expect");
      end else begin
        check_count++;
        if (out_data != expected[0]) begin
          report_mismatch(test_name, expected[0], out_data);
        end
        void'(expected.pop_front());
      end
    end
  end

  initial begin
    rst_n = 1'b1;
    in_enq = 1'b0;
    in_data = '0;
    out_full_n = 1'b1;
    rng = 32'd47091;
    wr_idx = 0;
    out_count = 0;
    check_count = 0;
    error_count = 0;
    test_name = "reset";
    $readmemh("bench/stream_patterns.txt", words);
    // each word leaves as its lanes, lowest lane first
    foreach (words[w]) begin
      for (int l = 0; l < LANES; l++) begin
        expected.push_back(words[w][l*LW +: LW]);
      end
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b0;
    test_name = "after_reset";
    repeat (3) begin
      @(negedge clk);
      check_count++;
      if (in_full_n != 1'b1) begin
        report_mismatch("after_reset in_full_n", 64'd1, 64'(in_full_n));
      end
      if (out_enq != 1'b0) begin
        report_mismatch("after_reset out_enq", 64'd0, 64'(out_enq));
      end
    end
    test_name = "no_backpressure";
    while (wr_idx < 4) drive_cycle(CLEAR);
    @(negedge clk);
    in_enq = 1'b0;
    // the first words drain completely before any back-pressure starts
    while (out_count < 4 * LANES) @(negedge clk);
    test_name = "random_backpressure";
    while (wr_idx < 10) drive_cycle(RANDOM);
    // hold the output off until the buffer refuses further words
    test_name = "long_stall";
    stall_cycles = 0;
    while (in_full_n && stall_cycles < 40) begin
      drive_cycle(STALL);
      stall_cycles++;
    end
    if (in_full_n) begin
      error_count++;
      $display("in_full_n never fell while the output was stalled");
    end
    repeat (10) begin
      drive_cycle(STALL);
      if (in_full_n) begin
        error_count++;
        $display("in_full_n rose although no lane had left");
      end
    end
    test_name = "stall_release";
    while (wr_idx < NUM_WORDS) drive_cycle(CLEAR);
    @(negedge clk);
    in_enq = 1'b0;
    test_name = "drain";
    while (out_count < NUM_WORDS * LANES) @(negedge clk);
    // idle a while so that any duplicate lane would show up
    repeat (20) @(negedge clk);
    check_count++;
    if (out_count != NUM_WORDS * LANES) begin
      report_mismatch("lane_count", 64'(NUM_WORDS * LANES), 64'(out_count));
    end
    if (expected.size() != 0) begin
      report_mismatch("lanes_left", 64'd0, 64'(expected.size()));
    end
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles with %0d lanes received", WATCHDOG_CYCLES,
             out_count);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- bench/stream_unpacker_sva.sv
module stream_unpacker_sva (
  input logic clk,
  input logic rst_n,
  input logic in_enq,
  input logic in_full_n,
  input logic out_enq,
  input logic out_full_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // a lane may only go to the interface FIFO while it has space
  a_out_space: assert property (@(posedge clk) disable iff (rst_n) out_enq |-> out_full_n)
    else $error("out_enq asserted while out_full_n is low");

  // the upstream agent must respect the full level of the fetch buffer
  a_in_space: assert property (@(posedge clk) disable iff (rst_n) in_enq |-> in_full_n)
    else $error("in_enq asserted while in_full_n is low");

  // nothing leaves the unpacker while reset is held
  a_reset_quiet: assert property (@(posedge clk) rst_n |-> !out_enq)
    else $error("out_enq asserted during reset");

endmodule

// attach the checks to every instance of the top level
bind stream_unpacker stream_unpacker_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_enq     (in_enq),
  .in_full_n  (in_full_n),
  .out_enq    (out_enq),
  .out_full_n (out_full_n)
);

//--- bench/tb_clock.sv
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // half of the 100 ns clock period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

//--- verilog/stream_unpacker.sv
module stream_unpacker import deagg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_word_u in_data,
  input  logic        in_enq,
  output logic        in_full_n,
  output lane_t       out_data,
  output logic        out_enq,
  input  logic        out_full_n
);

  // link between the fetch buffer and the deaggregator
  // buf_data lags buf_deq by one cycle
  fetch_word_u buf_data;
  logic        buf_empty_n;
  logic        buf_deq;

  // double buffer that holds up to two wide words from the upstream agent
  fetch_buffer u_fetch_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data     (in_data),
    .in_enq      (in_enq),
    .in_full_n   (in_full_n),
    .buf_data    (buf_data),
    .buf_deq     (buf_deq),
    .buf_empty_n (buf_empty_n)
  );

  // splits each word into lanes and hands them to the interface FIFO
  // one lane per transfer, lane 0 first
  deaggregator u_deaggregator (
    .clk         (clk),
    .rst_n       (rst_n),
    .buf_data    (buf_data),
    .buf_empty_n (buf_empty_n),
    .buf_deq     (buf_deq),
    .out_data    (out_data),
    .out_full_n  (out_full_n),
    .out_enq     (out_enq)
  );

endmodule

//--- verilog/deaggregator.sv
`include "deagg_config.svh"

module deaggregator import deagg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_word_u buf_data,
  input  logic        buf_empty_n,
  output logic        buf_deq,
  output lane_t       out_data,
  input  logic        out_full_n,
  output logic        out_enq
);

  localparam int LANES = `DEAGG_FETCH_WIDTH;
  localparam int DEPTH = `DEAGG_LANE_DEPTH;
  localparam int OCC_W = $clog2(DEPTH + 1);

  // buf_deq delayed by one cycle, aligned with the registered buffer data
  logic             deq_d;
  // lane currently allowed to leave
  lane_idx_t        sel;
  // words stored in the lane FIFOs plus the one in flight from the buffer
  logic [OCC_W-1:0] occ;

  lane_t            lane_dout [LANES];
  logic [LANES-1:0] lane_empty_n;
  logic [LANES-1:0] lane_deq;
  logic             last_deq;

  // one FIFO per lane, all written together by the delayed strobe
  // every lane FIFO holds the same number of words once its lane has left,
  // so the occupancy counter stands in for their full flags
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    lane_fifo #(
      .WIDTH ($bits(lane_t)),
      .DEPTH (DEPTH)
    ) u_lane_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .din     (buf_data.lanes[i]),
      .enq     (deq_d),
      .full_n  (),
      .dout    (lane_dout[i]),
      .deq     (lane_deq[i]),
      .empty_n (lane_empty_n[i])
    );

    // only the selected lane may leave, and only when downstream has space
    assign lane_deq[i] = (sel == lane_idx_t'(i)) && out_full_n && lane_empty_n[i];
  end

  // the output multiplexer follows the select counter
  assign out_data = lane_dout[sel];
  assign out_enq  = out_full_n && lane_empty_n[sel];

  // a word is only freed from the lane FIFOs when its last lane leaves
  assign last_deq = lane_deq[LANES-1];

  // pull a new word only while the lane FIFOs can take it,
  // counting the word that is still on its way from the buffer
  assign buf_deq = buf_empty_n && (occ < OCC_W'(DEPTH));

  always_ff @(posedge clk) begin
    if (rst_n) begin
      deq_d <= 1'b0;
    end else begin
      deq_d <= buf_deq;
    end
  end

  // lanes leave in order starting from lane 0, then wrap to the next word
  always_ff @(posedge clk) begin
    if (rst_n) begin
      sel <= '0;
    end else if (out_enq) begin
      if (sel == lane_idx_t'(LANES - 1)) begin
        sel <= '0;
      end else begin
        sel <= sel + 1'b1;
      end
    end
  end

  // a dequeue and a last-lane exit in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst_n) begin
      occ <= '0;
    end else if (buf_deq && !last_deq) begin
      occ <= occ + 1'b1;
    end else if (!buf_deq && last_deq) begin
      occ <= occ - 1'b1;
    end
  end

endmodule

//--- verilog/fetch_buffer.sv
module fetch_buffer import deagg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_word_u in_data,
  input  logic        in_enq,
  output logic        in_full_n,
  output fetch_word_u buf_data,
  input  logic        buf_deq,
  output logic        buf_empty_n
);

  localparam int WORD_W = $bits(fetch_word_u);

  // the two halves of the double buffer hold flat words
  logic [WORD_W-1:0] entry [2];
  // write toggle points at the half the next word lands in
  logic              wr_sel;
  // read toggle points at the oldest held word
  logic              rd_sel;
  // number of halves currently holding a word, 0 to 2
  logic [1:0]        count;
  logic              do_enq;
  logic              do_deq;

  assign in_full_n   = (count != 2'd2);
  assign buf_empty_n = (count != 2'd0);

  // the upstream agent only writes while in_full_n is high
  assign do_enq = in_enq && in_full_n;
  assign do_deq = buf_deq && buf_empty_n;

  // a new word lands in the half picked by the write toggle
  always_ff @(posedge clk) begin
    if (do_enq) begin
      entry[wr_sel] <= in_data.flat;
    end
  end

  // read data is registered, so the word follows its dequeue by one cycle
  // the deaggregator delays its own strobe by one cycle to match
  always_ff @(posedge clk) begin
    if (do_deq) begin
      buf_data.flat <= entry[rd_sel];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_sel <= 1'b0;
      rd_sel <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (do_enq) begin
        wr_sel <= ~wr_sel;
      end
      if (do_deq) begin
        rd_sel <= ~rd_sel;
      end
      // a write and a read in the same cycle swap one word for another
      case ({do_enq, do_deq})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- verilog/lane_fifo.sv
module lane_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  input  logic             enq,
  output logic             full_n,
  output logic [WIDTH-1:0] dout,
  input  logic             deq,
  output logic             empty_n
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_enq;
  logic             do_deq;

  // pointers walk a circular buffer whose depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full_n  = (count != CNT_W'(DEPTH));
  assign empty_n = (count != '0);

  // the head entry is visible without waiting for a dequeue
  assign dout = mem[rd_ptr];

  // a dequeue on an empty FIFO is ignored
  assign do_deq = deq && empty_n;
  // a full FIFO still accepts a word when the head leaves in the same cycle
  assign do_enq = enq && (full_n || do_deq);

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_deq) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // simultaneous enqueue and dequeue leave the count where it is
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- verilog/deagg_pkg.sv
`include "deagg_config.svh"

package deagg_pkg;

  // a single lane as it leaves the unpacker
  typedef logic [`DEAGG_DATA_WIDTH-1:0] lane_t;

  // selects one lane of a fetch word, sized for the lane count
  typedef logic [$clog2(`DEAGG_FETCH_WIDTH)-1:0] lane_idx_t;

  // one wide fetch word as written by the upstream agent
  // the fetch buffer only moves it around, so it uses the flat view
  // the deaggregator splits it, so it reads the lane view
  // lane 0 sits in the least significant bits and is emitted first
  typedef union packed {
    logic [`DEAGG_FETCH_WIDTH*`DEAGG_DATA_WIDTH-1:0] flat;
    lane_t [`DEAGG_FETCH_WIDTH-1:0]                  lanes;
  } fetch_word_u;

endpackage

//--- verilog/deagg_config.svh
`ifndef DEAGG_CONFIG_SVH
`define DEAGG_CONFIG_SVH

// bits carried by one lane of a fetch word
`define DEAGG_DATA_WIDTH 16

// number of lanes packed into one wide fetch word
`define DEAGG_FETCH_WIDTH 4

// entries in each per-lane FIFO inside the deaggregator
// the occupancy counter in the deaggregator stops issuing dequeues at this value
`define DEAGG_LANE_DEPTH 3

`endif
